/* hdl/gb_pkg.sv */
package gb_pkg;

	// ---------------------------------------
	// widths with a meaning
	// ---------------------------------------
	localparam int IRQ_BITS = 5;

	typedef logic [15:0]          addr_t;  // cpu address
	typedef logic [7:0]           data_t;  // one byte on the bus
	typedef logic [IRQ_BITS-1:0]  irq_t;   // one bit per interrupt source
	typedef logic [2:0]           bank_t;  // svbk bank number

	// interrupt bit positions, bit 0 has the highest priority
	localparam int IRQ_VBLANK = 0;
	localparam int IRQ_LCD    = 1;
	localparam int IRQ_TIMER  = 2;
	localparam int IRQ_SERIAL = 3;
	localparam int IRQ_JOYPAD = 4;

	// master side of the bus, one of rd/wr/iack per access
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;
		logic  wr;
		logic  iack;
	} cpu_bus_t;

	// select strobes out of the address decoder
	typedef struct packed {
		logic joy;
		logic sc;
		logic iflag;
		logic ie;
		logic svbk;   // colour mode only
		logic wram;
		logic zpram;
	} io_sel_t;

	// ---------------------------------------
	// memory map
	// ---------------------------------------
	localparam addr_t ADDR_JOYP = 16'hFF00;
	localparam addr_t ADDR_SB   = 16'hFF01;
	localparam addr_t ADDR_SC   = 16'hFF02;
	localparam addr_t ADDR_IF   = 16'hFF0F;
	localparam addr_t ADDR_SVBK = 16'hFF70;
	localparam addr_t ADDR_IE   = 16'hFFFF;

	localparam addr_t WRAM_LO  = 16'hC000;  // echo area included up to FDFF
	localparam addr_t WRAM_HI  = 16'hFDFF;
	localparam addr_t ZPRAM_LO = 16'hFF80;  // runs up to FFFE

	// rst vectors, 8 bytes apart
	localparam data_t IRQ_VEC_BASE = 8'h40;
	localparam data_t IRQ_VEC_NONE = 8'h55;

	localparam data_t OPEN_BUS = 8'hFF;  // nothing drives the data lines

endpackage

/* hdl/io_decode.sv */
`timescale 1ns/1ps

module io_decode (
	input  logic             clk_cpu,
	input  logic             reset,
	input  logic             gbc_mode,
	input  gb_pkg::cpu_bus_t bus,
	output gb_pkg::io_sel_t  sel,
	input  gb_pkg::data_t    joy_do,
	input  gb_pkg::data_t    sc_do,
	input  gb_pkg::data_t    if_do,
	input  gb_pkg::data_t    ie_do,
	input  gb_pkg::data_t    svbk_do,
	input  gb_pkg::data_t    wram_do,
	input  gb_pkg::data_t    zpram_do,
	input  gb_pkg::data_t    irq_vec,
	output gb_pkg::data_t    rdata
);
	import gb_pkg::*;

	typedef enum logic [3:0] {
		SRC_OPEN,
		SRC_JOY,
		SRC_SC,
		SRC_IF,
		SRC_IE,
		SRC_SVBK,
		SRC_WRAM,
		SRC_ZPRAM
	} src_e;

	src_e  src;       // source of the access in flight
	src_e  src_q;     // source of the last access cycle
	logic  iack_q;
	logic  load_q;    // previous cycle was rd or iack
	data_t rd_mux;

	// ---------------------------------------
	// address decode
	// ---------------------------------------
	always_comb begin
		sel.joy   = (bus.addr == ADDR_JOYP);
		sel.sc    = (bus.addr == ADDR_SC);
		sel.iflag = (bus.addr == ADDR_IF);
		sel.ie    = (bus.addr == ADDR_IE);
		sel.svbk  = gbc_mode && (bus.addr == ADDR_SVBK);  // absent on dmg
		sel.wram  = (bus.addr >= WRAM_LO) && (bus.addr <= WRAM_HI);
		sel.zpram = (bus.addr >= ZPRAM_LO) && (bus.addr != ADDR_IE);
	end

	always_comb begin
		if (sel.joy)                 src = SRC_JOY;
		else if (sel.sc)             src = SRC_SC;
		else if (sel.iflag)          src = SRC_IF;
		else if (sel.ie)             src = SRC_IE;
		else if (sel.svbk)           src = SRC_SVBK;
		else if (sel.wram)           src = SRC_WRAM;
		else if (sel.zpram)          src = SRC_ZPRAM;
		else                         src = SRC_OPEN;  // unmapped, SB idles high too
	end

	// ---------------------------------------
	// read data, one cycle after the access
	// ---------------------------------------
	always_comb begin
		case (src_q)
			SRC_JOY:   rd_mux = joy_do;
			SRC_SC:    rd_mux = sc_do;
			SRC_IF:    rd_mux = if_do;
			SRC_IE:    rd_mux = ie_do;
			SRC_SVBK:  rd_mux = svbk_do;
			SRC_WRAM:  rd_mux = wram_do;   // ram read finished last edge
			SRC_ZPRAM: rd_mux = zpram_do;
			default:   rd_mux = OPEN_BUS;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			src_q  <= SRC_OPEN;
			iack_q <= 1'b0;
			load_q <= 1'b0;
			rdata  <= OPEN_BUS;
		end else begin
			src_q  <= src;
			iack_q <= bus.iack;
			load_q <= bus.rd | bus.iack;
			if (load_q)
				rdata <= iack_q ? irq_vec : rd_mux;  // vector wins over bus data
		end
	end

endmodule

/* hdl/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::io_sel_t  sel,
	input  logic [2:0]       ext_irq,
	input  logic             serial_irq,
	input  logic             joy_irq,
	output gb_pkg::data_t    if_do,
	output gb_pkg::data_t    ie_do,
	output gb_pkg::data_t    irq_vec,
	output logic             irq_n
);
	import gb_pkg::*;

	irq_t if_r;      // IF, FF0F
	irq_t ie_r;      // IE, FFFF
	irq_t events;    // one-cycle request pulses
	irq_t pending;
	irq_t ack_mask;  // lowest pending bit only
	irq_t clr;
	logic iack_d;
	logic ack_done;

	// gather the sources into IF bit order
	always_comb begin
		events             = '0;
		events[IRQ_VBLANK] = ext_irq[0];
		events[IRQ_LCD]    = ext_irq[1];
		events[IRQ_TIMER]  = ext_irq[2];
		events[IRQ_SERIAL] = serial_irq;
		events[IRQ_JOYPAD] = joy_irq;
	end

	assign pending  = if_r & ie_r;
	assign ack_mask = pending & (~pending + irq_t'(1));  // isolate lowest set bit
	assign ack_done = iack_d & ~bus.iack;                // iack just dropped
	assign clr      = ack_done ? ack_mask : '0;

	// ---------------------------------------
	// flag and enable registers
	// ---------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_r   <= '0;
			ie_r   <= '0;
			iack_d <= 1'b0;
		end else begin
			iack_d <= bus.iack;
			if (sel.iflag && bus.wr)
				if_r <= irq_t'(bus.wdata);  // cpu write beats events and clear
			else
				if_r <= (if_r & ~clr) | events;
			if (sel.ie && bus.wr)
				ie_r <= irq_t'(bus.wdata);
		end
	end

	// fixed priority, vblank first
	always_comb begin
		irq_vec = IRQ_VEC_NONE;
		for (int i = IRQ_BITS - 1; i >= 0; i--) begin
			if (pending[i])
				irq_vec = IRQ_VEC_BASE + data_t'(i << 3);
		end
	end

	assign irq_n = ~|pending;             // low while anything enabled is pending
	assign if_do = {3'b111, if_r};        // unused bits float high
	assign ie_do = {3'b000, ie_r};

endmodule

/* hdl/joypad.sv */
`timescale 1ns/1ps

module joypad (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::io_sel_t  sel,
	input  gb_pkg::data_t    keys,     // active high, right..start
	output gb_pkg::data_t    joy_do,
	output logic             joy_irq
);
	import gb_pkg::*;

	logic [1:0] p54;       // 0 selects the group
	data_t      key_s1;
	data_t      key_s2;    // synchronised keys
	data_t      key_d;     // previous synchronised sample
	data_t      grp_en;
	logic [3:0] dir_n;
	logic [3:0] btn_n;

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54     <= 2'b00;
			key_s1  <= '0;
			key_s2  <= '0;
			key_d   <= '0;
			joy_irq <= 1'b0;
		end else begin
			if (sel.joy && bus.wr)
				p54 <= bus.wdata[5:4];
			key_s1  <= keys;
			key_s2  <= key_s1;
			key_d   <= key_s2;
			joy_irq <= |(key_s2 & ~key_d & grp_en);  // new press on a live line
		end
	end

	// ---------------------------------------
	// key matrix, lines pulled high
	// ---------------------------------------
	assign grp_en = {{4{~p54[1]}}, {4{~p54[0]}}};
	assign dir_n  = ~key_s2[3:0] | {4{p54[0]}};
	assign btn_n  = ~key_s2[7:4] | {4{p54[1]}};
	assign joy_do = {2'b11, p54, dir_n & btn_n};

endmodule

/* hdl/serial_port.sv */
`timescale 1ns/1ps

module serial_port #(
	parameter int SERIAL_DIV = 512
) (
	input  logic             clk_cpu,
	input  logic             reset,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::io_sel_t  sel,
	output gb_pkg::data_t    sc_do,
	output logic             serial_irq
);
	import gb_pkg::*;

	localparam int DIV_W = (SERIAL_DIV > 1) ? $clog2(SERIAL_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LOAD = DIV_W'(SERIAL_DIV - 1);

	logic             sc_start;  // transfer running
	logic             sc_int;    // internal shift clock
	logic [DIV_W-1:0] div_cnt;   // bit clock divider
	logic [3:0]       bit_cnt;   // bits still to shift
	logic             sc_wr;

	assign sc_wr = sel.sc & bus.wr;

	// ---------------------------------------
	// dummy transfer, nothing is shifted
	// ---------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start   <= 1'b0;
			sc_int     <= 1'b0;
			div_cnt    <= '0;
			bit_cnt    <= '0;
			serial_irq <= 1'b0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				sc_start <= bus.wdata[7];
				sc_int   <= bus.wdata[0];
				if (bus.wdata[7]) begin
					div_cnt <= DIV_LOAD;
					bit_cnt <= 4'd8;
				end
			end else if (sc_start && sc_int) begin  // external clock never ticks
				if (bit_cnt == 4'd0) begin
					serial_irq <= 1'b1;     // byte done
					sc_start   <= 1'b0;
				end else if (div_cnt == '0) begin
					div_cnt <= DIV_LOAD;
					bit_cnt <= bit_cnt - 4'd1;
				end else begin
					div_cnt <= div_cnt - 1'b1;
				end
			end
		end
	end

	assign sc_do = {sc_start, 6'h3F, sc_int};

endmodule

/* hdl/work_ram.sv */
`timescale 1ns/1ps

module work_ram #(
	parameter int WRAM_BANK_BITS = 3
) (
	input  logic             clk_cpu,
	input  logic             reset,
	input  logic             gbc_mode,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::io_sel_t  sel,
	output gb_pkg::data_t    wram_do,
	output gb_pkg::data_t    zpram_do,
	output gb_pkg::data_t    svbk_do
);
	import gb_pkg::*;

	localparam int WRAM_AW     = WRAM_BANK_BITS + 12;  // 4k per bank
	localparam int WRAM_DEPTH  = 2 ** WRAM_AW;
	localparam int ZPRAM_DEPTH = 127;                  // FF80..FFFE

	bank_t              bank;       // SVBK, never 0
	bank_t              bank_wr;
	logic [WRAM_AW-1:0] wram_addr;
	logic [6:0]         zp_addr;
	data_t              wram_mem  [WRAM_DEPTH];
	data_t              zpram_mem [ZPRAM_DEPTH];

	// ---------------------------------------
	// bank register
	// ---------------------------------------
	assign bank_wr = bank_t'(bus.wdata);

	always_ff @(posedge clk_cpu) begin
		if (reset)
			bank <= bank_t'(1);
		else if (sel.svbk && bus.wr)
			bank <= (bank_wr == '0) ? bank_t'(1) : bank_wr;  // 0 maps to 1
	end

	assign svbk_do = gbc_mode ? {5'h1F, bank} : OPEN_BUS;

	// D000 half is banked, C000 half always bank 0
	// echo area folds onto C000 since only bits 12..0 matter
	assign wram_addr = bus.addr[12] ? {bank[WRAM_BANK_BITS-1:0], bus.addr[11:0]}
	                                : {{WRAM_BANK_BITS{1'b0}}, bus.addr[11:0]};
	assign zp_addr   = bus.addr[6:0];

	// ---------------------------------------
	// memories, sync read and write
	// ---------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (sel.wram) begin
			if (bus.wr)
				wram_mem[wram_addr] <= bus.wdata;
			wram_do <= wram_mem[wram_addr];  // old data on a write cycle
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (sel.zpram) begin  // FFFF never gets here
			if (bus.wr)
				zpram_mem[zp_addr] <= bus.wdata;
			zpram_do <= zpram_mem[zp_addr];
		end
	end

endmodule

/* hdl/gb_io.sv */
`timescale 1ns/1ps

module gb_io #(
	parameter int SERIAL_DIV     = 512,  // clk_cpu cycles per serial bit
	parameter int WRAM_BANK_BITS = 3
) (
	input  logic             clk_cpu,
	input  logic             reset,
	input  logic             gbc_mode,
	input  gb_pkg::cpu_bus_t bus,
	input  gb_pkg::data_t    keys,
	input  logic [2:0]       ext_irq,  // vblank, lcd, timer pulses
	output gb_pkg::data_t    rdata,
	output logic             irq_n
);
	import gb_pkg::*;

	io_sel_t sel;
	data_t   joy_do;
	data_t   sc_do;
	data_t   if_do;
	data_t   ie_do;
	data_t   svbk_do;
	data_t   wram_do;
	data_t   zpram_do;
	data_t   irq_vec;
	logic    serial_irq;
	logic    joy_irq;

	// ---------------------------------------
	// decode and read path
	// ---------------------------------------
	io_decode u_decode (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.gbc_mode (gbc_mode),
		.bus      (bus),
		.sel      (sel),
		.joy_do   (joy_do),
		.sc_do    (sc_do),
		.if_do    (if_do),
		.ie_do    (ie_do),
		.svbk_do  (svbk_do),
		.wram_do  (wram_do),
		.zpram_do (zpram_do),
		.irq_vec  (irq_vec),
		.rdata    (rdata)
	);

	irq_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus),
		.sel        (sel),
		.ext_irq    (ext_irq),
		.serial_irq (serial_irq),
		.joy_irq    (joy_irq),
		.if_do      (if_do),
		.ie_do      (ie_do),
		.irq_vec    (irq_vec),
		.irq_n      (irq_n)
	);

	// ---------------------------------------
	// peripherals and memories
	// ---------------------------------------
	joypad u_joy (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus),
		.sel     (sel),
		.keys    (keys),
		.joy_do  (joy_do),
		.joy_irq (joy_irq)
	);

	serial_port #(.SERIAL_DIV(SERIAL_DIV)) u_serial (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus),
		.sel        (sel),
		.sc_do      (sc_do),
		.serial_irq (serial_irq)
	);

	work_ram #(.WRAM_BANK_BITS(WRAM_BANK_BITS)) u_ram (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.gbc_mode (gbc_mode),
		.bus      (bus),
		.sel      (sel),
		.wram_do  (wram_do),
		.zpram_do (zpram_do),
		.svbk_do  (svbk_do)
	);

endmodule

/* testbench/tb_tasks.svh */
// ---------------------------------------
// bus master, all tasks start and end 1 ns after an edge
// ---------------------------------------
task automatic bus_write(input addr_t a, input data_t d);
	bus.addr  = a;
	bus.wdata = d;
	bus.wr    = 1'b1;
	@(posedge clk_cpu);
	#1 bus.wr = 1'b0;
endtask

task automatic bus_read(input addr_t a, output data_t d);
	bus.addr = a;
	bus.rd   = 1'b1;
	@(posedge clk_cpu);
	#1 bus.rd = 1'b0;
	@(posedge clk_cpu);  // rdata loads here
	#1 d = rdata;
endtask

// acknowledge cycle, the vector comes back like read data
task automatic bus_iack(output data_t vec);
	bus.iack = 1'b1;
	@(posedge clk_cpu);
	#1 bus.iack = 1'b0;
	@(posedge clk_cpu);  // flag clears on this edge too
	#1 vec = rdata;
endtask

task automatic idle(input int n);
	repeat (n) @(posedge clk_cpu);
	#1;
endtask

// ---------------------------------------
// compare
// ---------------------------------------
task automatic check_data(input string name, input data_t exp, input data_t act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("FAIL %s: expected %02h, actual %02h", name, exp, act);
	end
endtask

task automatic check_irq_n(input string name, input logic exp, input logic act);
	checks++;
	if (act !== exp) begin
		errors++;
		$display("FAIL %s: expected %b, actual %b", name, exp, act);
	end
endtask

// ---------------------------------------
// directed tests
// ---------------------------------------
task automatic test_ram(input string name);
	data_t d;
	addr_t a;
	for (int i = 0; i < 256; i++) begin
		wram_ref[i] = data_t'($random(seed));
		bus_write(addr_t'(16'hC000 + i), wram_ref[i]);
	end
	for (int i = 0; i < 127; i++) begin
		zp_ref[i] = data_t'($random(seed));
		bus_write(addr_t'(ZPRAM_LO + i), zp_ref[i]);
	end
	for (int i = 0; i < 256; i++) begin
		a = addr_t'(16'hC000 + i);
		bus_read(a, d);
		check_data($sformatf("%s %04h", name, a), wram_ref[i], d);
		a = addr_t'(16'hE000 + i);  // echo of the same byte
		bus_read(a, d);
		check_data($sformatf("%s %04h", name, a), wram_ref[i], d);
	end
	for (int i = 0; i < 127; i++) begin
		a = addr_t'(ZPRAM_LO + i);
		bus_read(a, d);
		check_data($sformatf("%s %04h", name, a), zp_ref[i], d);
	end
	bus_read(16'hFEA0, d);  // unmapped
	check_data({name, " FEA0"}, OPEN_BUS, d);
	bus_read(ADDR_SB, d);
	check_data({name, " SB"}, 8'hFF, d);
endtask

task automatic test_banking(input string name);
	data_t d;
	gbc_mode = 1'b1;
	bus_write(16'hC000, 8'h5A);  // fixed bank 0 marker
	for (int b = 1; b < 8; b++) begin
		bus_write(ADDR_SVBK, data_t'(b));
		bus_write(16'hD000, data_t'(8'hB0 + b));
	end
	bus_write(ADDR_SVBK, 8'h00);  // stored as bank 1
	bus_read(ADDR_SVBK, d);
	check_data({name, " svbk 0"}, 8'hF9, d);
	for (int b = 1; b < 8; b++) begin
		bus_write(ADDR_SVBK, data_t'(b));
		bus_read(ADDR_SVBK, d);
		check_data($sformatf("%s svbk %0d", name, b), data_t'(8'hF8 | b), d);
		bus_read(16'hD000, d);
		check_data($sformatf("%s D000 bank %0d", name, b), data_t'(8'hB0 + b), d);
	end
	bus_read(16'hC000, d);
	check_data({name, " C000"}, 8'h5A, d);
	bus_write(ADDR_SVBK, 8'h02);
	idle(1);
	check_data({name, " rdata held"}, 8'h5A, rdata);  // no read since C000
	gbc_mode = 1'b0;  // dmg, no svbk
	bus_read(ADDR_SVBK, d);
	check_data({name, " dmg svbk"}, 8'hFF, d);
	bus_write(ADDR_SVBK, 8'h05);  // ignored
	gbc_mode = 1'b1;
	bus_read(ADDR_SVBK, d);
	check_data({name, " svbk after dmg write"}, 8'hFA, d);
endtask

task automatic test_interrupts(input string name);
	data_t d;
	bus_write(ADDR_IF, 8'h00);
	bus_write(ADDR_IE, 8'h1F);
	bus_read(ADDR_IE, d);
	check_data({name, " IE"}, 8'h1F, d);
	ext_irq = 3'b101;  // timer and vblank together
	@(posedge clk_cpu);
	#1 ext_irq = 3'b000;
	bus_read(ADDR_IF, d);
	check_data({name, " IF"}, 8'hE5, d);
	check_irq_n({name, " irq_n pending"}, 1'b0, irq_n);
	bus_iack(d);
	check_data({name, " vector vblank"}, 8'h40, d);
	check_irq_n({name, " irq_n after first clear"}, 1'b0, irq_n);
	bus_iack(d);
	check_data({name, " vector timer"}, 8'h50, d);
	check_irq_n({name, " irq_n after last clear"}, 1'b1, irq_n);
	bus_iack(d);
	check_data({name, " vector none"}, IRQ_VEC_NONE, d);
	bus_read(ADDR_IF, d);
	check_data({name, " IF cleared"}, 8'hE0, d);
endtask

task automatic test_joypad(input string name);
	data_t d;
	keys = 8'h00;
	bus_write(ADDR_JOYP, 8'h10);  // buttons only
	keys = 8'h10;                 // A
	idle(3);                      // through the synchroniser
	bus_read(ADDR_JOYP, d);
	check_data({name, " A held"}, 8'hDE, d);
	bus_write(ADDR_JOYP, 8'h20);  // directions only
	keys = 8'h01;                 // right
	idle(3);
	bus_read(ADDR_JOYP, d);
	check_data({name, " right held"}, 8'hEE, d);
	keys = 8'h00;
	idle(4);
	bus_write(ADDR_IF, 8'h00);
	keys = 8'h08;  // down press
	idle(4);       // read samples IF 5 edges after the press
	bus_read(ADDR_IF, d);
	check_data({name, " IF joypad"}, 8'hF0, d);
	keys = 8'h00;
	bus_write(ADDR_IF, 8'h00);
endtask

task automatic test_serial(input string name);
	data_t d;
	int    waited;
	bus_write(ADDR_IF, 8'h00);
	bus_write(ADDR_SC, 8'h81);  // start, internal clock
	bus_read(ADDR_SC, d);
	check_data({name, " SC busy"}, 8'hFF, d);
	waited = 0;
	while (d[7] && waited < 12 * SERIAL_DIV) begin
		bus_read(ADDR_SC, d);
		waited += 2;
	end
	checks++;
	if (d[7]) begin
		errors++;
		$display("serial transfer still busy after %0d cycles", waited);
	end
	bus_read(ADDR_IF, d);
	check_data({name, " IF serial"}, 8'hE8, d);
	bus_read(ADDR_SC, d);
	check_data({name, " SC done"}, 8'h7F, d);
	bus_write(ADDR_IF, 8'h00);
	bus_write(ADDR_SC, 8'h80);  // external clock, never ticks
	idle(12 * SERIAL_DIV);
	bus_read(ADDR_IF, d);
	check_data({name, " IF no transfer"}, 8'hE0, d);
	bus_write(ADDR_SC, 8'h00);
endtask

/* testbench/tb_gb_io.sv */
`timescale 1ns/1ps

module tb_gb_io;
	import gb_pkg::*;

	localparam int SERIAL_DIV     = 8;
	localparam int WRAM_BANK_BITS = 3;
	localparam int CLK_HALF       = 2;  // 4 ns period

	// ---------------------------------------
	// run length in clk_cpu cycles
	// ---------------------------------------
	// a write takes 1 cycle, a read or iack 2
	localparam int RAM_CYCLES  = (256 + 127) + 2 * (2 * 256 + 127 + 2);
	localparam int BANK_CYCLES = 100;
	localparam int IRQ_CYCLES  = 30;
	localparam int JOY_CYCLES  = 40;
	localparam int SER_CYCLES  = 2 * 12 * SERIAL_DIV + 30;  // poll limit plus idle check
	localparam int TIMEOUT_CYCLES = RAM_CYCLES + BANK_CYCLES + IRQ_CYCLES
	                              + JOY_CYCLES + SER_CYCLES + 200;

	logic     clk_cpu;
	logic     reset;
	logic     gbc_mode;
	cpu_bus_t bus;
	data_t    keys;
	logic [2:0] ext_irq;   // vblank, lcd, timer
	data_t    rdata;
	logic     irq_n;

	integer seed;
	int     checks;
	int     errors;
	int     tests;
	int     tests_failed;
	data_t  wram_ref [256];  // expected C000..C0FF
	data_t  zp_ref   [127];  // expected FF80..FFFE

	gb_io #(
		.SERIAL_DIV     (SERIAL_DIV),
		.WRAM_BANK_BITS (WRAM_BANK_BITS)
	) DUT (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.gbc_mode (gbc_mode),
		.bus      (bus),
		.keys     (keys),
		.ext_irq  (ext_irq),
		.rdata    (rdata),
		.irq_n    (irq_n)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #CLK_HALF clk_cpu = ~clk_cpu;
	end

	`include "tb_tasks.svh"

	// one summary line per finished test
	task automatic finish_test(input string name, input int err_start);
		tests++;
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - err_start);
		end
	endtask

	// ---------------------------------------
	// watchdog
	// ---------------------------------------
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_cpu);
		$display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int e0;
		seed         = 32'h6309;
		checks       = 0;
		errors       = 0;
		tests        = 0;
		tests_failed = 0;
		reset        = 1'b1;
		gbc_mode     = 1'b1;  // colour mode unless a test says otherwise
		bus          = '0;
		keys         = '0;
		ext_irq      = '0;
		repeat (2) @(posedge clk_cpu);
		#1 reset = 1'b0;

		e0 = errors;
		check_data("reset rdata", OPEN_BUS, rdata);
		check_irq_n("reset irq_n", 1'b1, irq_n);
		finish_test("reset", e0);

		e0 = errors;
		test_ram("ram");
		finish_test("ram", e0);
		e0 = errors;
		test_banking("banking");
		finish_test("banking", e0);
		e0 = errors;
		test_interrupts("interrupts");
		finish_test("interrupts", e0);
		e0 = errors;
		test_joypad("joypad");
		finish_test("joypad", e0);
		e0 = errors;
		test_serial("serial");
		finish_test("serial", e0);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
		         tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+testbench
hdl/gb_pkg.sv
hdl/io_decode.sv
hdl/irq_ctrl.sv
hdl/joypad.sv
hdl/serial_port.sv
hdl/work_ram.sv
hdl/gb_io.sv
testbench/tb_gb_io.sv
